// ==== source/arb_cfg_pkg.sv ====
//##########################################################################
// Sizing constants for the two-level round-robin arbiter.
// The top level takes its defaults from here and passes them down as
// module parameters. Code widths are derived, so only the group count
// and the group size need changing.
//##########################################################################

package arb_cfg_pkg;

  // Requesters inside one group
  localparam int GROUP_SIZE = 4;

  // Groups served by the group-level selector
  localparam int NUM_GROUPS = 4;

  // Total requesters seen at the top level
  localparam int NUM_REQ = NUM_GROUPS * GROUP_SIZE;

  // Binary position inside a group
  localparam int POS_W = (GROUP_SIZE > 1) ? $clog2(GROUP_SIZE) : 1;

  // Binary group number
  localparam int GRP_W = (NUM_GROUPS > 1) ? $clog2(NUM_GROUPS) : 1;

endpackage : arb_cfg_pkg

// ==== source/arb_types_pkg.sv ====
//##########################################################################
// Shared types for the arbiter hierarchy: per-group request masks,
// in-group position codes and group identifiers. Widths come from the
// sizing package, so both packages must be compiled in that order.
//##########################################################################

package arb_types_pkg;

  // One bit per requester of a group
  typedef logic [arb_cfg_pkg::GROUP_SIZE-1:0] grp_mask_t;

  // Position of the winner inside its group
  typedef logic [arb_cfg_pkg::POS_W-1:0] pos_code_t;

  // Group number, used for the turn pointer and the grant id
  typedef logic [arb_cfg_pkg::GRP_W-1:0] grp_id_t;

endpackage : arb_types_pkg

// ==== source/grp_arb_if.sv ====
//##########################################################################
// Link between the group selector and one in-group arbiter.
// The selector side hands over the request slice and the turn enable,
// the arbiter side returns its registered grant, the position code and
// the end-of-round release pulse. Plain levels, no handshake.
//##########################################################################

`timescale 1ns/1ps

interface grp_arb_if;

  // Request slice of this group, level
  arb_types_pkg::grp_mask_t req;
  // Group holds the arbitration turn
  logic                     en;
  // Registered one-hot grant
  arb_types_pkg::grp_mask_t gnt;
  // Registered winner position, aligned with gnt
  arb_types_pkg::pos_code_t pos;
  // Round finished, single cycle
  logic                     grp_release;

  modport sel (
    output req,
    output en,
    input  gnt,
    input  pos,
    input  grp_release
  );

  modport arb (
    input  req,
    input  en,
    output gnt,
    output pos,
    output grp_release
  );

endinterface : grp_arb_if

// ==== source/priority_arb.sv ====
//##########################################################################
// Fixed-priority arbiter, bit 0 has the highest priority.
// Purely combinational: the output is one-hot on the lowest set
// request bit, or all zero when nothing is requested.
//##########################################################################

`timescale 1ns/1ps

module priority_arb #(
  parameter int WIDTH = 4
) (
  input  logic [WIDTH-1:0] req_i,
  output logic [WIDTH-1:0] gnt_o
);

  // Some lower-index request is already active
  logic [WIDTH-1:0] lower_req;

  // Nothing sits below bit 0
  assign lower_req[0] = 1'b0;

  // Ripple chain of lower requests
  for (genvar i = 1; i < WIDTH; i++) begin : g_chain
    assign lower_req[i] = lower_req[i-1] | req_i[i-1];
  end

  // A bit wins only if no lower bit is requesting
  assign gnt_o = req_i & ~lower_req;

endmodule : priority_arb

// ==== source/y_roundrobin.sv ====
//##########################################################################
// Round-robin arbiter inside one group.
// A thermometer mask hides the requesters already served in the current
// round; the lowest masked request wins. Grant and position code are
// registered, so the grant trails the request by one clock. The release
// pulse tells the group selector that this round is over.
//##########################################################################

`timescale 1ns/1ps

module y_roundrobin #(
  parameter int GROUP_SIZE = arb_cfg_pkg::GROUP_SIZE
) (
  input logic   clk,
  input logic   reset,
  grp_arb_if.arb grp
);

  // Positions still eligible in this round
  arb_types_pkg::grp_mask_t mask_q;
  arb_types_pkg::grp_mask_t nxt_mask;

  // Requests left after masking
  logic [GROUP_SIZE-1:0] mask_req;
  // One-hot winner among masked requests
  logic [GROUP_SIZE-1:0] mask_gnt;
  // Positions strictly above the winner
  logic [GROUP_SIZE-1:0] above_win;

  arb_types_pkg::pos_code_t win_pos;
  logic                     round_end;

  // Registered outputs
  arb_types_pkg::grp_mask_t gnt_q;
  arb_types_pkg::pos_code_t pos_q;

  assign mask_req = grp.req & mask_q;

  priority_arb #(
    .WIDTH (GROUP_SIZE)
  ) u_masked_arb (
    .req_i (mask_req),
    .gnt_o (mask_gnt)
  );

  // Winner bit and every bit below it cleared, rest set
  assign above_win = ~(mask_gnt | (mask_gnt - 1'b1));

  always_comb begin
    nxt_mask  = mask_q;
    win_pos   = '0;
    round_end = 1'b0;
    // One-hot to binary
    for (int i = 0; i < GROUP_SIZE; i++) begin
      if (mask_gnt[i]) begin
        win_pos = arb_types_pkg::pos_code_t'(i);
      end
    end
    if (|mask_req) begin
      // Next grant must come from above the winner
      nxt_mask  = above_win;
      // Nobody masked is left above, round ends here
      round_end = ~|(mask_req & above_win);
    end else if (|grp.req) begin
      // Only already-served requesters remain
      // Reload and give up the turn, no grant this cycle
      nxt_mask  = '1;
      round_end = 1'b1;
    end
  end

  // Release only while holding the turn
  assign grp.grp_release = grp.en & round_end;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      mask_q <= '1;
      gnt_q  <= '0;
      pos_q  <= '0;
    end else if (grp.en) begin
      mask_q <= nxt_mask;
      gnt_q  <= mask_gnt;
      pos_q  <= win_pos;
    end else begin
      // Out of turn: fresh round next time, no grant
      mask_q <= '1;
      gnt_q  <= '0;
      pos_q  <= '0;
    end
  end

  assign grp.gnt = gnt_q;
  assign grp.pos = pos_q;

endmodule : y_roundrobin

// ==== source/x_group_sel.sv ====
//##########################################################################
// Group-level round-robin selector.
// Gives the arbitration turn to one group at a time and moves it on
// when that group releases, or when it has nothing to ask for. Groups
// without requests are skipped. The registered group grants are merged
// into the flat grant vector and the requester id.
//##########################################################################

`timescale 1ns/1ps

module x_group_sel #(
  parameter int NUM_GROUPS = arb_cfg_pkg::NUM_GROUPS,
  parameter int GROUP_SIZE = arb_cfg_pkg::GROUP_SIZE
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      enable_i,
  input  logic [NUM_GROUPS*GROUP_SIZE-1:0]          req_i,
  output logic [NUM_GROUPS*GROUP_SIZE-1:0]          gnt_o,
  output logic [$clog2(NUM_GROUPS*GROUP_SIZE)-1:0] gnt_id_o,
  output logic                                      gnt_valid_o,
  grp_arb_if.sel                                    grp [NUM_GROUPS]
);

  // Group currently holding the turn
  arb_types_pkg::grp_id_t ptr_q;
  arb_types_pkg::grp_id_t next_ptr;
  // Group that owned the turn last cycle, lines up with the grants
  arb_types_pkg::grp_id_t gnt_grp_q;

  // Per-group status flattened out of the interface array
  logic [NUM_GROUPS-1:0]    grp_busy;
  logic [NUM_GROUPS-1:0]    grp_rel;
  arb_types_pkg::pos_code_t grp_pos [NUM_GROUPS];

  logic advance;

  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_grp
    assign grp[g].req  = req_i[g*GROUP_SIZE +: GROUP_SIZE];
    assign grp[g].en   = enable_i & (ptr_q == arb_types_pkg::grp_id_t'(g));
    assign grp_busy[g] = |req_i[g*GROUP_SIZE +: GROUP_SIZE];
    assign grp_rel[g]  = grp[g].grp_release;
    assign grp_pos[g]  = grp[g].pos;
    // Only the granting group has a nonzero vector
    assign gnt_o[g*GROUP_SIZE +: GROUP_SIZE] = grp[g].gnt;
  end

  // Next requesting group after the current one, wrapping around
  always_comb begin : next_grp
    int unsigned cand;
    next_ptr = ptr_q;
    // Walk from far to near so the nearest busy group wins
    for (int k = NUM_GROUPS; k >= 1; k--) begin
      cand = (int'(ptr_q) + k) % NUM_GROUPS;
      if (grp_busy[cand]) begin
        next_ptr = arb_types_pkg::grp_id_t'(cand);
      end
    end
  end

  // Round over, or an idle group sitting on the turn
  assign advance = grp_rel[ptr_q] | ~grp_busy[ptr_q];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      ptr_q     <= '0;
      gnt_grp_q <= '0;
    end else if (!enable_i) begin
      // Disabled: restart from group 0
      ptr_q     <= '0;
      gnt_grp_q <= '0;
    end else begin
      gnt_grp_q <= ptr_q;
      if (advance) begin
        ptr_q <= next_ptr;
      end
    end
  end

  assign gnt_valid_o = |gnt_o;

  // Group number on top, position inside the group below
  assign gnt_id_o = {gnt_grp_q, grp_pos[gnt_grp_q]};

endmodule : x_group_sel

// ==== source/hier_arb_top.sv ====
//##########################################################################
// Two-level round-robin arbiter, top level.
// Requests are split into groups of equal size; each group has its own
// round-robin arbiter and a group selector passes the turn between
// them. Grants are registered one-hot levels with one clock latency,
// gnt_id_o carries the binary index of the granted requester.
//##########################################################################

`timescale 1ns/1ps

module hier_arb_top #(
  parameter int NUM_GROUPS = arb_cfg_pkg::NUM_GROUPS,
  parameter int GROUP_SIZE = arb_cfg_pkg::GROUP_SIZE
) (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      enable_i,
  input  logic [NUM_GROUPS*GROUP_SIZE-1:0]          req_i,
  output logic [NUM_GROUPS*GROUP_SIZE-1:0]          gnt_o,
  output logic [$clog2(NUM_GROUPS*GROUP_SIZE)-1:0] gnt_id_o,
  output logic                                      gnt_valid_o
);

  // One link per group between selector and group arbiter
  grp_arb_if grp_link [NUM_GROUPS] ();

  // Turn pointer, request split and grant merge
  x_group_sel #(
    .NUM_GROUPS (NUM_GROUPS),
    .GROUP_SIZE (GROUP_SIZE)
  ) u_group_sel (
    .clk         (clk),
    .reset       (reset),
    .enable_i    (enable_i),
    .req_i       (req_i),
    .gnt_o       (gnt_o),
    .gnt_id_o    (gnt_id_o),
    .gnt_valid_o (gnt_valid_o),
    .grp         (grp_link)
  );

  // In-group arbiters
  for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
    y_roundrobin #(
      .GROUP_SIZE (GROUP_SIZE)
    ) u_group_arb (
      .clk   (clk),
      .reset (reset),
      .grp   (grp_link[g])
    );
  end

endmodule : hier_arb_top

// ==== sim/hier_arb_assertions.sv ====
//##########################################################################
// Concurrent checks for the two-level round-robin arbiter.
// Bound to hier_arb_top, so it sees the top-level ports directly. Each
// failing assertion raises $error and bumps err_cnt, which the
// testbench watches to stop the run.
//##########################################################################

`timescale 1ns/1ps

module hier_arb_assertions #(
  parameter int NUM_GROUPS = arb_cfg_pkg::NUM_GROUPS,
  parameter int GROUP_SIZE = arb_cfg_pkg::GROUP_SIZE
) (
  input logic                                      clk,
  input logic                                      reset,
  input logic                                      enable_i,
  input logic [NUM_GROUPS*GROUP_SIZE-1:0]          req_i,
  input logic [NUM_GROUPS*GROUP_SIZE-1:0]          gnt_i,
  input logic [$clog2(NUM_GROUPS*GROUP_SIZE)-1:0] gnt_id_i,
  input logic                                      gnt_valid_i
);

  localparam int NUM_REQ = NUM_GROUPS * GROUP_SIZE;
  localparam int ID_W    = $clog2(NUM_REQ);

  // Failed checks so far
  int err_cnt = 0;

  // Requests that took part in the last decision
  logic [NUM_REQ-1:0] req_en_q;
  // Grants to other requesters since own last grant
  int                 wait_cnt [NUM_REQ];

  // Full load with the arbiter running
  logic all_on;
  assign all_on = enable_i & (&req_i);

  // One-hot of the lowest set bit, zero for an empty vector
  function automatic logic [NUM_REQ-1:0] lowest_bit(input logic [NUM_REQ-1:0] vec);
    logic [NUM_REQ-1:0] res;
    res = '0;
    for (int i = NUM_REQ - 1; i >= 0; i--) begin
      if (vec[i]) begin
        res    = '0;
        res[i] = 1'b1;
      end
    end
    return res;
  endfunction

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      req_en_q <= '0;
      for (int i = 0; i < NUM_REQ; i++) begin
        wait_cnt[i] <= 0;
      end
    end else begin
      req_en_q <= enable_i ? req_i : '0;
      for (int i = 0; i < NUM_REQ; i++) begin
        // Restart the count when not waiting or just served
        if (!req_en_q[i] || gnt_i[i]) begin
          wait_cnt[i] <= 0;
        end else if (|gnt_i) begin
          wait_cnt[i] <= wait_cnt[i] + 1;
        end
      end
    end
  end

  // Quiet outputs during reset
  a_reset_quiet : assert property (@(posedge clk)
      reset |-> (gnt_i == '0) && !gnt_valid_i)
    else begin
      $error("Grant active while reset is asserted");
      err_cnt++;
    end

  // One cycle after a disabled cycle nothing is granted
  a_disabled_quiet : assert property (@(posedge clk) disable iff (reset)
      !$past(enable_i) |-> (gnt_i == '0) && !gnt_valid_i)
    else begin
      $error("Grant active one cycle after enable_i was low");
      err_cnt++;
    end

  a_onehot : assert property (@(posedge clk) disable iff (reset)
      $onehot0(gnt_i))
    else begin
      $error("More than one grant bit set");
      err_cnt++;
    end

  // Winner must have asked one cycle earlier
  a_from_request : assert property (@(posedge clk) disable iff (reset)
      (gnt_i & ~($past(req_i) & {NUM_REQ{$past(enable_i)}})) == '0)
    else begin
      $error("Grant to a requester that was not requesting");
      err_cnt++;
    end

  a_valid_or : assert property (@(posedge clk) disable iff (reset)
      gnt_valid_i == (|gnt_i))
    else begin
      $error("gnt_valid_o differs from the OR of gnt_o");
      err_cnt++;
    end

  // Steady full load never leaves a gap
  a_walk_no_gap : assert property (@(posedge clk) disable iff (reset)
      ($past(all_on) && $past(all_on, 2)) |-> gnt_valid_i)
    else begin
      $error("Idle cycle under full load");
      err_cnt++;
    end

  // Steady full load steps to the next index, wrapping at the top
  a_walk_order : assert property (@(posedge clk) disable iff (reset)
      ($past(all_on) && $past(all_on, 2) && $past(gnt_valid_i))
      |-> gnt_i == {$past(gnt_i[NUM_REQ-2:0]), $past(gnt_i[NUM_REQ-1])})
    else begin
      $error("Full-load grant is not the successor of the previous one");
      err_cnt++;
    end

  // Restart with group 0 busy serves its lowest requester
  a_restart_grp0 : assert property (@(posedge clk) disable iff (reset)
      (!$past(enable_i, 2) && $past(enable_i) && (|$past(req_i[GROUP_SIZE-1:0])))
      |-> gnt_i == lowest_bit($past(req_i)))
    else begin
      $error("First grant after restart is not the lowest requester");
      err_cnt++;
    end

  // Restart with group 0 idle, requests held: one idle cycle first
  a_restart_later : assert property (@(posedge clk) disable iff (reset)
      (!$past(enable_i, 3) && $past(enable_i, 2) && $past(enable_i)
       && ($past(req_i[GROUP_SIZE-1:0], 2) == '0) && ($past(req_i) == $past(req_i, 2)))
      |-> gnt_i == lowest_bit($past(req_i)))
    else begin
      $error("First grant after restart skips the lowest busy group");
      err_cnt++;
    end

  for (genvar i = 0; i < NUM_REQ; i++) begin : g_req
    // Id names the granted bit
    a_gnt_id : assert property (@(posedge clk) disable iff (reset)
        gnt_i[i] |-> gnt_id_i == ID_W'(i))
      else begin
        $error("gnt_id_o does not match granted requester %0d", i);
        err_cnt++;
      end

    // Bounded wait for a held request
    a_fair : assert property (@(posedge clk) disable iff (reset)
        wait_cnt[i] <= NUM_REQ - 1)
      else begin
        $error("Requester %0d waited past %0d other grants", i, NUM_REQ - 1);
        err_cnt++;
      end
  end

endmodule : hier_arb_assertions

bind hier_arb_top hier_arb_assertions #(
  .NUM_GROUPS (NUM_GROUPS),
  .GROUP_SIZE (GROUP_SIZE)
) u_assertions (
  .clk         (clk),
  .reset       (reset),
  .enable_i    (enable_i),
  .req_i       (req_i),
  .gnt_i       (gnt_o),
  .gnt_id_i    (gnt_id_o),
  .gnt_valid_i (gnt_valid_o)
);

// ==== sim/tb_hier_arb.sv ====
//##########################################################################
// Testbench for the two-level round-robin arbiter.
// Runs request phases and enable pulses through the DUT. Checking is
// done by the bound assertion module; this module watches its error
// count, limits the run with a watchdog and reports the result.
//##########################################################################

`timescale 1ns/1ps

module tb_hier_arb;

  localparam int NUM_GROUPS = arb_cfg_pkg::NUM_GROUPS;
  localparam int GROUP_SIZE = arb_cfg_pkg::GROUP_SIZE;
  localparam int NUM_REQ    = arb_cfg_pkg::NUM_REQ;
  localparam int ID_W       = $clog2(NUM_REQ);

  // Clock and drive timing in ns
  localparam int HALF_PERIOD  = 20;
  localparam int CLK_PERIOD   = 2 * HALF_PERIOD;
  localparam int DRIVE_DLY    = 2;
  localparam int RESET_CYCLES = 4;

  // Phase lengths in cycles
  localparam int FULL_CYCLES    = 100;
  localparam int CONST_PATTERNS = 16;
  localparam int CONST_HOLD     = 40;
  localparam int CHANGE_CYCLES  = 500;
  localparam int PULSE_COUNT    = 12;
  localparam int PULSE_HOLD     = 12;
  localparam int PULSE_LOW_MAX  = 3;
  localparam int DRAIN_CYCLES   = 4;
  localparam int MARGIN_CYCLES  = 200;

  localparam int RUN_CYCLES = RESET_CYCLES + 2 * FULL_CYCLES
                            + CONST_PATTERNS * CONST_HOLD + CHANGE_CYCLES
                            + PULSE_COUNT * (2 * PULSE_HOLD + PULSE_LOW_MAX)
                            + DRAIN_CYCLES;
  localparam int WATCHDOG_NS = (RUN_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

  logic               clk = 1'b0;
  logic               reset;
  logic               enable;
  logic [NUM_REQ-1:0] req;
  logic [NUM_REQ-1:0] gnt;
  logic [ID_W-1:0]    gnt_id;
  logic               gnt_valid;

  hier_arb_top #(
    .NUM_GROUPS (NUM_GROUPS),
    .GROUP_SIZE (GROUP_SIZE)
  ) dut_i (
    .clk         (clk),
    .reset       (reset),
    .enable_i    (enable),
    .req_i       (req),
    .gnt_o       (gnt),
    .gnt_id_o    (gnt_id),
    .gnt_valid_o (gnt_valid)
  );

  always #HALF_PERIOD clk = ~clk;

  // Wait n rising edges, then move to the drive point
  task automatic advance(input int n);
    repeat (n) @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Random request vector, sometimes sparse
  function automatic logic [NUM_REQ-1:0] random_req();
    logic [31:0] a;
    logic [31:0] b;
    a = $urandom();
    b = $urandom();
    if (a[31]) begin
      return a[NUM_REQ-1:0] & b[NUM_REQ-1:0];
    end
    return a[NUM_REQ-1:0];
  endfunction

  initial begin : stimulus
    int                 low_len;
    logic [NUM_REQ-1:0] pattern;
    void'($urandom(31));
    reset  = 1'b1;
    enable = 1'b0;
    req    = '0;
    advance(RESET_CYCLES);
    reset  = 1'b0;
    enable = 1'b1;
    // Full load
    req = '1;
    advance(FULL_CYCLES);
    // Held patterns
    for (int p = 0; p < CONST_PATTERNS; p++) begin
      req = random_req();
      advance(CONST_HOLD);
    end
    // New pattern every cycle
    for (int c = 0; c < CHANGE_CYCLES; c++) begin
      req = random_req();
      advance(1);
    end
    // Enable pulses with requests held across them
    for (int p = 0; p < PULSE_COUNT; p++) begin
      pattern = random_req();
      // Every other pulse leaves group 0 idle
      if (p % 2 == 1) begin
        pattern[GROUP_SIZE-1:0] = '0;
      end
      req = pattern;
      advance(PULSE_HOLD);
      enable  = 1'b0;
      low_len = 1 + int'($urandom_range(PULSE_LOW_MAX - 1));
      advance(low_len);
      enable = 1'b1;
      advance(PULSE_HOLD);
    end
    // Full load again after the last restart
    req = '1;
    advance(FULL_CYCLES);
    req = '0;
    advance(DRAIN_CYCLES);
    if (dut_i.u_assertions.err_cnt == 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("TESTBENCH FAILED");
      $fatal(1, "Assertion errors counted at end of run");
    end
  end

  // Stop at the first assertion failure
  initial begin : error_monitor
    wait (dut_i.u_assertions.err_cnt != 0);
    $display("Mismatch at %0t ns: assertion check in hier_arb_assertions failed", $time);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at first assertion failure");
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Timeout: run did not finish within %0d cycles", RUN_CYCLES + MARGIN_CYCLES);
    $display("TESTBENCH FAILED");
    $fatal(1, "Watchdog expired");
  end

endmodule : tb_hier_arb

// ==== sim.f ====
source/arb_cfg_pkg.sv
source/arb_types_pkg.sv
source/grp_arb_if.sv
source/priority_arb.sv
source/y_roundrobin.sv
source/x_group_sel.sv
source/hier_arb_top.sv
sim/hier_arb_assertions.sv
sim/tb_hier_arb.sv

// ==== Makefile ====
# Verilator build for the two-level round-robin arbiter

VERILATOR  ?= verilator
TOP        := tb_hier_arb
FILELIST   := sim.f
BUILD_DIR  := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
RUN_FLAGS  := +verilator+error+limit+10

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Build and run; a $fatal in the run gives a nonzero exit status
sim:
	$(VERILATOR) $(SIM_FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
